/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cop_tb
FILELIST  = tb.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* logic/cop_ctrl_fsm.sv */
// Control FSM for the CPU req/ack handshake and the decode, execute, writeback sequence
`timescale 1ns/100ps

module cop_ctrl_fsm (
    input  logic     g_clk_i,
    input  logic     rst_i,
    input  logic     cpu_req_i,
    output logic     cpu_ack_o,
    output logic     cpu_exception_o,
    cop_issue_if.ctrl ctl
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_DECODE,
        S_EXEC,
        S_WB,
        S_ACK
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   exc_q;      // Exception captured at end of decode

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:   if (cpu_req_i) state_d = S_DECODE;
            S_DECODE: state_d = ctl.decoded.exception ? S_ACK : S_EXEC;
            S_EXEC:   if (ctl.exec_done) state_d = S_WB;
            S_WB:     state_d = S_ACK;
            S_ACK:    if (!cpu_req_i) state_d = S_IDLE; // Hold until CPU drops req
            default:  state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge g_clk_i) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            exc_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_DECODE) begin
                exc_q <= ctl.decoded.exception;
            end
        end
    end

    // Start pulse lands as the FSM enters execute
    assign ctl.exec_start = (state_q == S_DECODE) && !ctl.decoded.exception;

    assign ctl.wb_en      = (state_q == S_WB) && ctl.decoded.writes_cpr;

    assign cpu_ack_o       = (state_q == S_ACK);
    assign cpu_exception_o = exc_q;

endmodule

/* logic/cop_idecode.sv */
// Combinational instruction decoder with illegal-instruction detection
`timescale 1ns/100ps

module cop_idecode (
    input  logic [31:0] insn_i,
    cop_issue_if.dec    dec
);

    cop_pkg::cop_decoded_t d;
    cop_pkg::cop_funct_e   funct;
    cop_pkg::cop_pw_e      pw;
    logic                  opc_ok;
    logic                  funct_ok;
    logic                  pw_ok;
    logic                  is_parith;
    logic                  is_move;

    assign funct  = cop_pkg::cop_funct_e'(insn_i[cop_pkg::COP_FUNCT_MSB:cop_pkg::COP_FUNCT_LSB]);
    assign pw     = cop_pkg::cop_pw_e'(insn_i[cop_pkg::COP_PW_MSB:cop_pkg::COP_PW_LSB]);
    assign opc_ok = insn_i[cop_pkg::COP_OPC_MSB:cop_pkg::COP_OPC_LSB] == cop_pkg::COP_MAJOR_OPCODE;

    // Anything above xcr2gpr is unallocated
    assign funct_ok = funct <= cop_pkg::XCR2GPR;

    assign pw_ok = (pw == cop_pkg::PW_32) || (pw == cop_pkg::PW_16) || (pw == cop_pkg::PW_8);

    assign is_parith = funct_ok && (funct <= cop_pkg::PSRL_I);
    assign is_move   = (funct == cop_pkg::GPR2XCR) || (funct == cop_pkg::XCR2GPR);

    always_comb begin
        d.subclass = funct;
        d.pw       = pw;
        d.crd      = insn_i[cop_pkg::COP_CRD_MSB:cop_pkg::COP_CRD_LSB];
        d.crs1     = insn_i[cop_pkg::COP_CRS1_MSB:cop_pkg::COP_CRS1_LSB];
        d.crs2     = insn_i[cop_pkg::COP_CRS2_MSB:cop_pkg::COP_CRS2_LSB];
        d.shamt    = insn_i[cop_pkg::COP_SHAMT_MSB:cop_pkg::COP_SHAMT_LSB];

        // Bad pack width only matters for packed arithmetic
        d.exception = !opc_ok || !funct_ok || (is_parith && !pw_ok);

        if (d.exception) begin
            d.cls = cop_pkg::CLASS_NONE;
        end else if (is_parith) begin
            d.cls = cop_pkg::CLASS_PACKED_ARITH;
        end else if (is_move) begin
            d.cls = cop_pkg::CLASS_MOVE;
        end else begin
            d.cls = cop_pkg::CLASS_NONE;
        end

        d.writes_cpr = !d.exception && (funct != cop_pkg::XCR2GPR); // xcr2gpr only reads
    end

    assign dec.decoded = d;

endmodule

/* logic/cop_issue_if.sv */
// Issue interface between decoder, control FSM and datapath
`timescale 1ns/100ps

interface cop_issue_if #(
    parameter int XLEN = 32
);

    cop_pkg::cop_decoded_t decoded;     // From the decoder
    logic                  exec_start;  // One-cycle pulse into execute
    logic                  wb_en;       // CPR write enable
    logic                  exec_done;   // One-cycle pulse, result valid
    logic [XLEN-1:0]       exec_result;

    modport dec (
        output decoded
    );

    modport ctrl (
        input  decoded, exec_done,
        output exec_start, wb_en
    );

    modport dp (
        input  decoded, exec_start,
        output exec_done, exec_result
    );

endinterface

/* logic/cop_palu.sv */
// Packed arithmetic and move datapath with an iterative lane-wise multiplier
`timescale 1ns/100ps

module cop_palu #(
    parameter int XLEN = 32
) (
    input  logic                    g_clk_i,
    input  logic                    rst_i,
    cop_issue_if.dp                 dp,
    input  logic [XLEN-1:0]         rs1_data_i,
    input  logic [XLEN-1:0]         rs2_data_i,
    input  logic [XLEN-1:0]         gpr_i,
    input  logic [$clog2(XLEN)-1:0] step_idx_i,
    input  logic                    step_last_i,
    output logic                    step_start_o,
    output logic                    step_run_o
);

    logic                  busy_q;     // Multiply in progress
    logic                  done_q;
    logic [XLEN-1:0]       result_q;   // Also the multiply accumulator
    logic [XLEN-1:0]       mcand_q;
    logic [XLEN-1:0]       mplier_q;
    cop_pkg::cop_pw_e      mul_pw_q;
    logic [XLEN-1:0]       alu_res;
    logic [XLEN-1:0]       partial;
    logic                  is_mul;

    function automatic int lane_bits(cop_pkg::cop_pw_e pw);
        case (pw)
            cop_pkg::PW_16: return 16;
            cop_pkg::PW_8:  return 8;
            default:        return XLEN;
        endcase
    endfunction

    // Carry-isolated add or subtract, top bit of each lane fixed up by xor
    function automatic logic [XLEN-1:0] lane_add(logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                                                 int lw, logic sub);
        logic [XLEN-1:0] h;
        h = '0;
        for (int i = 0; i < XLEN; i++) begin
            h[i] = (i % lw) == (lw - 1);
        end
        if (sub) begin
            return ((a | h) - (b & ~h)) ^ ((a ^ ~b) & h);
        end
        return ((a & ~h) + (b & ~h)) ^ ((a ^ b) & h);
    endfunction

    // Zero once the amount reaches the lane width
    function automatic logic [XLEN-1:0] lane_shift(logic [XLEN-1:0] a, int sh, int lw,
                                                   logic left);
        logic [XLEN-1:0] r;
        int              k;
        r = '0;
        for (int i = 0; i < XLEN; i++) begin
            k = i % lw;
            if (left && (k >= sh)) begin
                r[i] = a[i-sh];
            end else if (!left && (k + sh < lw)) begin
                r[i] = a[i+sh];
            end
        end
        return r;
    endfunction

    // Multiplicand lane shifted by the bit offset of step idx, other lanes zero
    function automatic logic [XLEN-1:0] mul_partial(logic [XLEN-1:0] a, int idx, int lw);
        logic [XLEN-1:0] r;
        int              k;
        int              base;
        r    = '0;
        k    = idx % lw;
        base = idx - k;
        for (int j = 0; j < XLEN; j++) begin
            if ((j >= base + k) && (j < base + lw)) begin
                r[j] = a[j-k];
            end
        end
        return r;
    endfunction

    assign is_mul = dp.decoded.subclass == cop_pkg::PMUL_L;

    always_comb begin
        int lw;
        lw = lane_bits(dp.decoded.pw);
        case (dp.decoded.subclass)
            cop_pkg::PADD:    alu_res = lane_add(rs1_data_i, rs2_data_i, lw, 1'b0);
            cop_pkg::PSUB:    alu_res = lane_add(rs1_data_i, rs2_data_i, lw, 1'b1);
            cop_pkg::PSLL_I:  alu_res = lane_shift(rs1_data_i, int'(dp.decoded.shamt), lw, 1'b1);
            cop_pkg::PSRL_I:  alu_res = lane_shift(rs1_data_i, int'(dp.decoded.shamt), lw, 1'b0);
            cop_pkg::GPR2XCR: alu_res = gpr_i;
            cop_pkg::XCR2GPR: alu_res = rs1_data_i;
            default:          alu_res = '0;
        endcase
    end

    assign partial = mplier_q[step_idx_i] ?
                     mul_partial(mcand_q, int'(step_idx_i), lane_bits(mul_pw_q)) : '0;

    always_ff @(posedge g_clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (dp.exec_start) begin
                busy_q <= is_mul;
                done_q <= !is_mul;  // Single-cycle ops finish next edge
            end else if (busy_q && step_last_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (dp.exec_start) begin
            result_q <= is_mul ? '0 : alu_res;
            mcand_q  <= rs1_data_i;
            mplier_q <= rs2_data_i;
            mul_pw_q <= dp.decoded.pw;
        end else if (busy_q) begin
            result_q <= lane_add(result_q, partial, lane_bits(mul_pw_q), 1'b0);
        end
    end

    assign step_start_o   = dp.exec_start && is_mul;
    assign step_run_o     = busy_q;
    assign dp.exec_done   = done_q;
    assign dp.exec_result = result_q;

endmodule

/* logic/cop_pkg.sv */
// Instruction field positions, opcodes, classes, pack widths and the decoded instruction struct
package cop_pkg;

    // Defaults for the top-level parameters
    localparam int COP_NUM_CPRS = 16;
    localparam int COP_XLEN     = 32;

    // Instruction field positions
    localparam int COP_OPC_MSB   = 6;
    localparam int COP_OPC_LSB   = 0;
    localparam int COP_FUNCT_MSB = 31;
    localparam int COP_FUNCT_LSB = 28;
    localparam int COP_PW_MSB    = 27;
    localparam int COP_PW_LSB    = 25;
    localparam int COP_CRD_MSB   = 24;
    localparam int COP_CRD_LSB   = 21;
    localparam int COP_CRS1_MSB  = 19;
    localparam int COP_CRS1_LSB  = 16;
    localparam int COP_CRS2_MSB  = 13;
    localparam int COP_CRS2_LSB  = 10;
    localparam int COP_SHAMT_MSB = 14;
    localparam int COP_SHAMT_LSB = 10;

    localparam logic [6:0] COP_MAJOR_OPCODE = 7'b0001011; // custom-0

    typedef enum logic [3:0] {
        PADD    = 4'd0,
        PSUB    = 4'd1,
        PMUL_L  = 4'd2,
        PSLL_I  = 4'd3,
        PSRL_I  = 4'd4,
        GPR2XCR = 4'd5,
        XCR2GPR = 4'd6  // 7 to 15 are illegal
    } cop_funct_e;

    typedef enum logic [2:0] {
        CLASS_NONE         = 3'd0,
        CLASS_PACKED_ARITH = 3'd1,
        CLASS_MOVE         = 3'd2
    } cop_class_e;

    typedef enum logic [2:0] {
        PW_32 = 3'd0,
        PW_16 = 3'd1,
        PW_8  = 3'd2
    } cop_pw_e;

    typedef struct packed {
        cop_class_e cls;
        cop_funct_e subclass;
        cop_pw_e    pw;
        logic [3:0] crd;
        logic [3:0] crs1;
        logic [3:0] crs2;
        logic [4:0] shamt;
        logic       writes_cpr;
        logic       exception;
    } cop_decoded_t;

endpackage

/* logic/cop_regfile.sv */
// Coprocessor register file, two combinational read ports and one write port
`timescale 1ns/100ps

module cop_regfile #(
    parameter int NUM_REGS = 16,
    parameter int XLEN     = 32
) (
    input  logic                        g_clk_i,
    input  logic                        rst_i,
    input  logic [$clog2(NUM_REGS)-1:0] raddr1_i,
    input  logic [$clog2(NUM_REGS)-1:0] raddr2_i,
    output logic [XLEN-1:0]             rdata1_o,
    output logic [XLEN-1:0]             rdata2_o,
    input  logic                        wen_i,
    input  logic [$clog2(NUM_REGS)-1:0] waddr_i,
    input  logic [XLEN-1:0]             wdata_i
);

    logic [XLEN-1:0] cpr_q [NUM_REGS];

    // All CPRs read as zero after reset
    always_ff @(posedge g_clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                cpr_q[i] <= '0;
            end
        end else if (wen_i) begin
            cpr_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = cpr_q[raddr1_i];
    assign rdata2_o = cpr_q[raddr2_i];

endmodule

/* logic/cop_step_counter.sv */
// Iteration counter pacing the multi-cycle packed multiply
`timescale 1ns/100ps

module cop_step_counter #(
    parameter int WIDTH = 32
) (
    input  logic                     g_clk_i,
    input  logic                     rst_i,
    input  logic                     step_start_i,
    input  logic                     step_run_i,
    output logic [$clog2(WIDTH)-1:0] step_idx_o,
    output logic                     step_last_o
);

    localparam int IDX_W = $clog2(WIDTH);

    logic [IDX_W-1:0] idx_q;

    always_ff @(posedge g_clk_i) begin
        if (rst_i) begin
            idx_q <= '0;
        end else if (step_start_i) begin
            idx_q <= '0;
        end else if (step_run_i) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign step_idx_o  = idx_q;
    assign step_last_o = idx_q == IDX_W'(WIDTH - 1); // Final shift-add step

endmodule

/* logic/cop_top.sv */
// Coprocessor top level with decoder, control FSM, step counter, datapath and CPRs
`timescale 1ns/100ps

module cop_top #(
    parameter int NUM_REGS = cop_pkg::COP_NUM_CPRS,
    parameter int XLEN     = cop_pkg::COP_XLEN
) (
    input  logic            g_clk_i,
    input  logic            rst_i,
    input  logic            cpu_req_i,
    input  logic [31:0]     cpu_insn_i,
    input  logic [XLEN-1:0] cpu_rs1_i,
    output logic            cpu_ack_o,
    output logic [XLEN-1:0] cpu_result_o,
    output logic            cpu_exception_o
);

    localparam int AW    = $clog2(NUM_REGS);
    localparam int IDX_W = $clog2(XLEN);

    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  rs2_data;
    logic [IDX_W-1:0] step_idx;
    logic             step_last;
    logic             step_start;
    logic             step_run;

    cop_issue_if #(.XLEN(XLEN)) issue ();

    cop_idecode u_idecode (
        .insn_i (cpu_insn_i),
        .dec    (issue)
    );

    cop_ctrl_fsm u_ctrl (
        .g_clk_i         (g_clk_i),
        .rst_i           (rst_i),
        .cpu_req_i       (cpu_req_i),
        .cpu_ack_o       (cpu_ack_o),
        .cpu_exception_o (cpu_exception_o),
        .ctl             (issue)
    );

    cop_step_counter #(.WIDTH(XLEN)) u_step (
        .g_clk_i      (g_clk_i),
        .rst_i        (rst_i),
        .step_start_i (step_start),
        .step_run_i   (step_run),
        .step_idx_o   (step_idx),
        .step_last_o  (step_last)
    );

    cop_palu #(.XLEN(XLEN)) u_palu (
        .g_clk_i      (g_clk_i),
        .rst_i        (rst_i),
        .dp           (issue),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .gpr_i        (cpu_rs1_i),
        .step_idx_i   (step_idx),
        .step_last_i  (step_last),
        .step_start_o (step_start),
        .step_run_o   (step_run)
    );

    cop_regfile #(.NUM_REGS(NUM_REGS), .XLEN(XLEN)) u_regfile (
        .g_clk_i  (g_clk_i),
        .rst_i    (rst_i),
        .raddr1_i (issue.decoded.crs1[AW-1:0]),
        .raddr2_i (issue.decoded.crs2[AW-1:0]),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .wen_i    (issue.wb_en),
        .waddr_i  (issue.decoded.crd[AW-1:0]),
        .wdata_i  (issue.exec_result)
    );

    // Result held for the CPU until the next instruction completes
    always_ff @(posedge g_clk_i) begin
        if (issue.exec_done) begin
            cpu_result_o <= issue.exec_result;
        end
    end

endmodule

/* tb.f */
logic/cop_pkg.sv
logic/cop_issue_if.sv
logic/cop_idecode.sv
logic/cop_ctrl_fsm.sv
logic/cop_step_counter.sv
logic/cop_palu.sv
logic/cop_regfile.sv
logic/cop_top.sv
tests/cop_assertions.sv
tests/cop_tb.sv

/* tests/cop_assertions.sv */
// Handshake and writeback assertions for the control FSM, bound into cop_ctrl_fsm
`timescale 1ns/100ps

module cop_assertions (
    input logic g_clk_i,
    input logic rst_i,
    input logic cpu_req_i,
    input logic cpu_ack_i,
    input logic wb_en_i,
    input logic exc_i
);

    // Ack only ever answers a pending request
    ack_needs_req: assert property (@(posedge g_clk_i) disable iff (rst_i)
        $rose(cpu_ack_i) |-> cpu_req_i)
        else $error("cpu_ack_o rose while cpu_req_i was low");

    ack_falls_after_req: assert property (@(posedge g_clk_i) disable iff (rst_i)
        $fell(cpu_ack_i) |-> $past(!cpu_req_i))
        else $error("cpu_ack_o fell before cpu_req_i was dropped");

    // An excepting instruction never reaches writeback
    no_wb_on_exc: assert property (@(posedge g_clk_i) disable iff (rst_i)
        !(wb_en_i && exc_i))
        else $error("CPR write enabled together with a registered exception");

endmodule

bind cop_ctrl_fsm cop_assertions u_assertions (
    .g_clk_i   (g_clk_i),
    .rst_i     (rst_i),
    .cpu_req_i (cpu_req_i),
    .cpu_ack_i (cpu_ack_o),
    .wb_en_i   (ctl.wb_en),
    .exc_i     (exc_q)
);

/* tests/cop_tb.sv */
// Testbench for cop_top with a stimulus table, a shadow CPR model, compare tasks and a timeout
`timescale 1ns/100ps

module cop_tb;

    localparam int         XLEN         = cop_pkg::COP_XLEN;
    localparam int         NUM_REGS     = cop_pkg::COP_NUM_CPRS;
    localparam int         RESET_CYCLES = 10;
    localparam int         MAX_TESTS    = 128;
    localparam logic [6:0] OPC          = cop_pkg::COP_MAJOR_OPCODE;
    localparam logic [6:0] BAD_OPC      = 7'b0110011; // OP, not custom-0

    logic            g_clk_i    = 1'b0;
    logic            rst_i      = 1'b1;
    logic            cpu_req_i  = 1'b0;
    logic [31:0]     cpu_insn_i = '0;
    logic [XLEN-1:0] cpu_rs1_i  = '0;
    logic            cpu_ack_o;
    logic [XLEN-1:0] cpu_result_o;
    logic            cpu_exception_o;

    logic [31:0]     tab_insn [MAX_TESTS];
    logic [XLEN-1:0] tab_gpr  [MAX_TESTS];
    logic            tab_exc  [MAX_TESTS];   // Exception expected
    logic [XLEN-1:0] shadow   [NUM_REGS];    // Reference copy of the CPRs
    int              n_tests;
    int              seed;
    int              cycles;
    int              cycle_limit;
    int              errors;
    int              failed_tests;
    logic            test_bad;

    cop_top #(.NUM_REGS(NUM_REGS), .XLEN(XLEN)) cop_top_i (
        .g_clk_i         (g_clk_i),
        .rst_i           (rst_i),
        .cpu_req_i       (cpu_req_i),
        .cpu_insn_i      (cpu_insn_i),
        .cpu_rs1_i       (cpu_rs1_i),
        .cpu_ack_o       (cpu_ack_o),
        .cpu_result_o    (cpu_result_o),
        .cpu_exception_o (cpu_exception_o)
    );

    always #20 g_clk_i = ~g_clk_i;

    // Run limit is set once the table length is known
    always @(posedge g_clk_i) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the DUT did not complete the table within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Bits 13:10 double as crs2, so src2 carries either crs2 or the shift amount
    function automatic logic [31:0] encode(logic [6:0] opc, logic [3:0] funct, logic [2:0] pw,
                                           logic [3:0] crd, logic [3:0] crs1, logic [4:0] src2);
        logic [31:0] w;
        w = '0;
        w[cop_pkg::COP_OPC_MSB:cop_pkg::COP_OPC_LSB]     = opc;
        w[cop_pkg::COP_FUNCT_MSB:cop_pkg::COP_FUNCT_LSB] = funct;
        w[cop_pkg::COP_PW_MSB:cop_pkg::COP_PW_LSB]       = pw;
        w[cop_pkg::COP_CRD_MSB:cop_pkg::COP_CRD_LSB]     = crd;
        w[cop_pkg::COP_CRS1_MSB:cop_pkg::COP_CRS1_LSB]   = crs1;
        w[cop_pkg::COP_SHAMT_MSB:cop_pkg::COP_SHAMT_LSB] = src2;
        return w;
    endfunction

    function automatic int lane_width(logic [2:0] pw);
        if (pw == 3'd1) begin
            return 16;
        end else if (pw == 3'd2) begin
            return 8;
        end
        return XLEN;
    endfunction

    // Each lane handled as a separate narrow number, then packed back
    function automatic logic [XLEN-1:0] lane_op(logic [3:0] funct, int lw, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b, int sh);
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        logic [XLEN-1:0] z;
        logic [XLEN-1:0] r;
        mask = (lw >= XLEN) ? '1 : ((XLEN'(1) << lw) - XLEN'(1));
        r    = '0;
        for (int base = 0; base < XLEN; base += lw) begin
            x = (a >> base) & mask;
            y = (b >> base) & mask;
            case (funct)
                cop_pkg::PADD:   z = x + y;
                cop_pkg::PSUB:   z = x - y;
                cop_pkg::PMUL_L: z = x * y;
                cop_pkg::PSLL_I: z = (sh >= lw) ? '0 : (x << sh);
                cop_pkg::PSRL_I: z = (sh >= lw) ? '0 : (x >> sh);
                default:         z = '0;
            endcase
            r = r | ((z & mask) << base);
        end
        return r;
    endfunction

    task automatic add_test(input logic [31:0] insn, input logic [XLEN-1:0] gpr, input logic exc);
        tab_insn[n_tests] = insn;
        tab_gpr[n_tests]  = gpr;
        tab_exc[n_tests]  = exc;
        n_tests++;
    endtask

    task automatic build_table();
        logic [4:0] shamts [4];
        shamts = '{5'd3, 5'd8, 5'd17, 5'd31};  // Some at or above the lane width
        // Reset state reads where the first carries a pack width that moves ignore
        add_test(encode(OPC, cop_pkg::XCR2GPR, 3'd5, 4'd0, 4'd0, 5'd0), XLEN'($random(seed)), 1'b0);
        add_test(encode(OPC, cop_pkg::XCR2GPR, 3'd0, 4'd0, 4'd7, 5'd0), XLEN'($random(seed)), 1'b0);
        add_test(encode(OPC, cop_pkg::XCR2GPR, 3'd0, 4'd0, 4'd15, 5'd0),
                 XLEN'($random(seed)), 1'b0);
        for (int i = 0; i < NUM_REGS; i++) begin
            add_test(encode(OPC, cop_pkg::GPR2XCR, 3'd0, 4'(i), 4'd0, 5'd0),
                     XLEN'($random(seed)), 1'b0);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            add_test(encode(OPC, cop_pkg::XCR2GPR, 3'd0, 4'd0, 4'(i), 5'd0), '0, 1'b0);
        end
        for (int w = 0; w < 3; w++) begin
            add_test(encode(OPC, cop_pkg::PADD, 3'(w), 4'(w), 4'(w + 4), 5'(w + 8)), '0, 1'b0);
            add_test(encode(OPC, cop_pkg::PSUB, 3'(w), 4'(w + 12), 4'(w + 1), 5'(w + 6)),
                     '0, 1'b0);
        end
        for (int w = 0; w < 3; w++) begin
            for (int k = 0; k < 4; k++) begin
                add_test(encode(OPC, cop_pkg::PSLL_I, 3'(w), 4'(w * 4 + k), 4'(k + 5), shamts[k]),
                         '0, 1'b0);
                add_test(encode(OPC, cop_pkg::PSRL_I, 3'(w), 4'(15 - w * 4 - k), 4'(w + 2),
                                shamts[k]), '0, 1'b0);
            end
        end
        // Fresh random operands ahead of each multiply
        for (int w = 0; w < 3; w++) begin
            add_test(encode(OPC, cop_pkg::GPR2XCR, 3'd0, 4'(w), 4'd0, 5'd0),
                     XLEN'($random(seed)), 1'b0);
            add_test(encode(OPC, cop_pkg::GPR2XCR, 3'd0, 4'(w + 5), 4'd0, 5'd0),
                     XLEN'($random(seed)), 1'b0);
            add_test(encode(OPC, cop_pkg::PMUL_L, 3'(w), 4'(13 + w), 4'(w), 5'(w + 5)), '0, 1'b0);
            add_test(encode(OPC, cop_pkg::XCR2GPR, 3'd0, 4'd0, 4'(13 + w), 5'd0), '0, 1'b0);
        end
        // Illegal encodings each followed by a read of the target CPR
        add_test(encode(BAD_OPC, cop_pkg::GPR2XCR, 3'd0, 4'd2, 4'd0, 5'd0),
                 XLEN'($random(seed)), 1'b1);
        add_test(encode(OPC, cop_pkg::XCR2GPR, 3'd0, 4'd0, 4'd2, 5'd0), '0, 1'b0);
        add_test(encode(OPC, 4'd9, 3'd0, 4'd3, 4'd1, 5'd2), XLEN'($random(seed)), 1'b1);
        add_test(encode(OPC, cop_pkg::XCR2GPR, 3'd0, 4'd0, 4'd3, 5'd0), '0, 1'b0);
        add_test(encode(OPC, cop_pkg::PADD, 3'd3, 4'd4, 4'd1, 5'd2), '0, 1'b1);
        add_test(encode(OPC, cop_pkg::XCR2GPR, 3'd0, 4'd0, 4'd4, 5'd0), '0, 1'b0);
        add_test(encode(OPC, cop_pkg::PADD, 3'd7, 4'd5, 4'd6, 5'd7), '0, 1'b1);
        add_test(encode(OPC, cop_pkg::XCR2GPR, 3'd0, 4'd0, 4'd5, 5'd0), '0, 1'b0);
    endtask

    task automatic run_model(input logic [31:0] insn, input logic [XLEN-1:0] gpr, input logic exc,
                             output logic [XLEN-1:0] exp);
        logic [3:0] funct;
        logic [3:0] crd;
        logic [3:0] crs1;
        logic [3:0] crs2;
        int         sh;
        funct = insn[cop_pkg::COP_FUNCT_MSB:cop_pkg::COP_FUNCT_LSB];
        crd   = insn[cop_pkg::COP_CRD_MSB:cop_pkg::COP_CRD_LSB];
        crs1  = insn[cop_pkg::COP_CRS1_MSB:cop_pkg::COP_CRS1_LSB];
        crs2  = insn[cop_pkg::COP_CRS2_MSB:cop_pkg::COP_CRS2_LSB];
        sh    = int'(insn[cop_pkg::COP_SHAMT_MSB:cop_pkg::COP_SHAMT_LSB]);
        if (funct == cop_pkg::GPR2XCR) begin
            exp = gpr;
        end else if (funct == cop_pkg::XCR2GPR) begin
            exp = shadow[crs1];
        end else begin
            exp = lane_op(funct, lane_width(insn[cop_pkg::COP_PW_MSB:cop_pkg::COP_PW_LSB]),
                          shadow[crs1], shadow[crs2], sh);
        end
        if (!exc && funct != cop_pkg::XCR2GPR) begin
            shadow[crd] = exp;
        end
    endtask

    task automatic check_result(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: cpu_result_o got %h expected %h", $time, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_exception(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: cpu_exception_o got %b expected %b", $time, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic run_test(input int idx);
        logic [XLEN-1:0] exp_result;
        @(posedge g_clk_i);
        cpu_req_i  <= 1'b1;
        cpu_insn_i <= tab_insn[idx];
        cpu_rs1_i  <= tab_gpr[idx];
        @(negedge g_clk_i);
        while (!cpu_ack_o) @(negedge g_clk_i);
        test_bad = 1'b0;
        run_model(tab_insn[idx], tab_gpr[idx], tab_exc[idx], exp_result);
        check_exception(cpu_exception_o, tab_exc[idx]);
        if (!tab_exc[idx]) begin
            check_result(cpu_result_o, exp_result); // Result only moves when execute ran
        end
        @(posedge g_clk_i);
        cpu_req_i <= 1'b0;
        @(negedge g_clk_i);
        while (cpu_ack_o) @(negedge g_clk_i);
        if (test_bad) begin
            failed_tests++;
        end
        $display("test %0d insn %h gpr %h: %s", idx, tab_insn[idx], tab_gpr[idx],
                 test_bad ? "FAIL" : "ok");
    endtask

    initial begin
        seed         = 39066;
        cycles       = 0;
        cycle_limit  = 0;
        errors       = 0;
        failed_tests = 0;
        n_tests      = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        build_table();
        cycle_limit = n_tests * (XLEN + 10) + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge g_clk_i);
        rst_i <= 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d mismatches", n_tests,
                 n_tests - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
